// File: roulette_ctrl.f
+incdir+source
source/roulette_pkg.sv
source/bet_amount_entry.sv
source/pick_entry.sv
source/round_sequencer.sv
source/roulette_ctrl.sv
verification/tb_roulette_ctrl.sv

// File: run_sim.sh
#!/bin/sh
# Build the roulette controller testbench with Verilator and run it
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert \
    --top-module tb_roulette_ctrl \
    -f roulette_ctrl.f \
    -o tb_roulette_ctrl

# $fatal exits nonzero, so the log carries the verdict
./obj_dir/tb_roulette_ctrl > sim.log 2>&1 || true
cat sim.log

if grep -q "sim failed" sim.log; then
    echo "simulation FAILED, see sim.log"
    exit 1
fi
echo "simulation finished without failure"

// File: source/bet_amount_entry.sv
/*
 * Bet amount entry.
 * Builds a decimal amount from digit keys and checks it against the balance.
 */
`timescale 1ns/1ps
`include "roulette_consts.svh"
`default_nettype none

module bet_amount_entry
    import roulette_pkg::*;
(
    input  wire              clk,
    input  wire              rst,
    input  wire bet_ctl_t    ctl,
    input  wire key_code_t   digit,
    input  wire money_t      current_money,
    input  wire              round_clear,
    output money_t           bet_amount,
    output logic             bet_ok
);

    money_t next_amount;

    // ------------------------------
    // Decimal accumulate
    // ------------------------------
    // Shift one decimal place and add, wraps at 16 bits
    always_comb begin
        next_amount = bet_amount * money_t'(10);
        next_amount = next_amount + money_t'(digit);
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            bet_amount <= '0;
        end else if (round_clear || ctl.clear) begin
            // '#', rejected '*' or a new round
            bet_amount <= '0;
        end else if (ctl.load_digit) begin
            bet_amount <= next_amount;
        end
    end

    // ------------------------------
    // Balance check
    // ------------------------------
    // Zero bets are never accepted
    assign bet_ok = (bet_amount != '0) && (bet_amount <= current_money);

    // Sequencer only loads real digit keys
    a_digit_range: assert property (
        @(posedge clk) disable iff (rst)
        ctl.load_digit |-> (digit <= key_code_t'(`ROULETTE_MAX_DIGIT))
    ) else $error("bet_amount_entry: load_digit with a non-digit key");

endmodule

`default_nettype wire

// File: source/pick_entry.sv
/*
 * Bet count and number entry.
 * Holds how many numbers are bet on and the zero-based wheel slots chosen.
 */
`timescale 1ns/1ps
`include "roulette_consts.svh"
`default_nettype none

module pick_entry
    import roulette_pkg::*;
(
    input  wire              clk,
    input  wire              rst,
    input  wire pick_ctl_t   ctl,
    input  wire key_code_t   digit,
    output pick_count_t      bet_count,
    output picks_t           picks,
    output logic             count_ok,
    output logic             picks_ok
);

    // Numbers entered so far this round
    pick_count_t entered;
    logic        count_key;
    logic        number_key;
    slot_t       new_slot;

    // ------------------------------
    // Key range checks
    // ------------------------------
    // Count keys 1 to 4
    assign count_key = (digit >= key_code_t'(1)) &&
                       (digit <= key_code_t'(`ROULETTE_MAX_PICKS));

    // Number keys 1 to 8, only while slots remain
    assign number_key = (digit >= key_code_t'(1)) &&
                        (digit <= key_code_t'(`ROULETTE_NUM_SLOTS)) &&
                        (entered < bet_count);

    // Keypad is one-based, wheel is zero-based
    assign new_slot = slot_t'(digit - key_code_t'(1));

    // ------------------------------
    // Bet count register
    // ------------------------------
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            bet_count <= '0;
        end else if (ctl.round_clear || ctl.clear_count) begin
            bet_count <= '0;
        end else if (ctl.load_count && count_key) begin
            bet_count <= pick_count_t'(digit);
        end
    end

    // ------------------------------
    // Number slots and entry counter
    // ------------------------------
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            entered <= '0;
            picks   <= '0;
        end else if (ctl.round_clear || ctl.clear_numbers) begin
            entered <= '0;
            picks   <= '0;
        end else if (ctl.load_number && number_key) begin
            // Fill slots in key order
            case (entered)
                3'd0: picks.slot0 <= new_slot;
                3'd1: picks.slot1 <= new_slot;
                3'd2: picks.slot2 <= new_slot;
                3'd3: picks.slot3 <= new_slot;
                default: ;
            endcase
            entered <= entered + pick_count_t'(1);
        end
    end

    // ------------------------------
    // Status back to the sequencer
    // ------------------------------
    assign count_ok = (bet_count >= pick_count_t'(1)) &&
                      (bet_count <= pick_count_t'(`ROULETTE_MAX_PICKS));

    // All chosen numbers are in
    assign picks_ok = (entered == bet_count) && (bet_count != '0);

    // Counter stays within the chosen count across all entry steps
    a_entered_le_count: assert property (
        @(posedge clk) disable iff (rst)
        entered <= bet_count
    ) else $error("pick_entry: entered count above bet_count");

endmodule

`default_nettype wire

// File: source/roulette_consts.svh
/*
 * Game constants for the roulette controller.
 * Keypad codes, pick limits and field widths, included by the package and RTL.
 */
`ifndef ROULETTE_CONSTS_SVH
`define ROULETTE_CONSTS_SVH

// ------------------------------
// Keypad codes
// ------------------------------
// Digits 0 to 9 come through as their own value
`define ROULETTE_KEY_STAR  10
`define ROULETTE_KEY_HASH  11
`define ROULETTE_MAX_DIGIT 9

// ------------------------------
// Pick limits
// ------------------------------
// Bet count range is 1 to 4
`define ROULETTE_MAX_PICKS 4
// Wheel positions, entered as 1 to 8
`define ROULETTE_NUM_SLOTS 8

// ------------------------------
// Widths
// ------------------------------
`define ROULETTE_MONEY_W 16
`define ROULETTE_KEY_W   4
`define ROULETTE_COUNT_W 3
`define ROULETTE_SLOT_W  3

`endif

// File: source/roulette_ctrl.sv
/*
 * Top level of the roulette game controller.
 * Connects the round sequencer to the bet amount and pick entry units.
 */
`timescale 1ns/1ps
`default_nettype none

module roulette_ctrl
    import roulette_pkg::*;
(
    input  wire              clk,
    input  wire              rst,
    // Keypad strobe
    input  wire              key_valid,
    input  wire key_code_t   key_value,
    // Spinner, hit check and money manager flags
    input  wire              spin_done,
    input  wire              win_flag,
    input  wire              money_zero,
    input  wire              money_10000,
    input  wire money_t      current_money,
    // Game status
    output game_state_e      state,
    output pick_count_t      bet_count,
    output money_t           bet_amount,
    output picks_t           picks,
    output round_pulses_t    pulses
);

    bet_ctl_t  bet_ctl;
    pick_ctl_t pick_ctl;
    logic      bet_ok;
    logic      count_ok;
    logic      picks_ok;

    // ------------------------------
    // Game FSM
    // ------------------------------
    round_sequencer i_round_sequencer (
        .clk         (clk),
        .rst         (rst),
        .key_valid   (key_valid),
        .key_value   (key_value),
        .spin_done   (spin_done),
        .win_flag    (win_flag),
        .money_zero  (money_zero),
        .money_10000 (money_10000),
        .bet_ok      (bet_ok),
        .count_ok    (count_ok),
        .picks_ok    (picks_ok),
        .state       (state),
        .bet_ctl     (bet_ctl),
        .pick_ctl    (pick_ctl),
        .pulses      (pulses)
    );

    // Amount unit shares the round clear with the pick unit
    bet_amount_entry i_bet_amount_entry (
        .clk           (clk),
        .rst           (rst),
        .ctl           (bet_ctl),
        .digit         (key_value),
        .current_money (current_money),
        .round_clear   (pick_ctl.round_clear),
        .bet_amount    (bet_amount),
        .bet_ok        (bet_ok)
    );

    pick_entry i_pick_entry (
        .clk       (clk),
        .rst       (rst),
        .ctl       (pick_ctl),
        .digit     (key_value),
        .bet_count (bet_count),
        .picks     (picks),
        .count_ok  (count_ok),
        .picks_ok  (picks_ok)
    );

endmodule

`default_nettype wire

// File: source/roulette_pkg.sv
/*
 * Shared types of the roulette controller.
 * Import with a wildcard in the module header.
 */
`default_nettype none

`include "roulette_consts.svh"

package roulette_pkg;

    // Scalar widths with a meaning
    typedef logic [`ROULETTE_KEY_W-1:0]   key_code_t;
    typedef logic [`ROULETTE_MONEY_W-1:0] money_t;
    typedef logic [`ROULETTE_COUNT_W-1:0] pick_count_t;
    typedef logic [`ROULETTE_SLOT_W-1:0]  slot_t;

    // ------------------------------
    // Game states, codes kept from the LCD/piezo decode
    // ------------------------------
    typedef enum logic [3:0] {
        IDLE         = 4'd0,
        BET_MONEY    = 4'd1,
        BET_SELECT   = 4'd2,
        NUMBER_INPUT = 4'd3,
        START_SPIN   = 4'd4,
        SLOW_DOWN    = 4'd5,
        STOP_RESULT  = 4'd6,
        WIN_DISPLAY  = 4'd7,
        LOSE_DISPLAY = 4'd8,
        UPDATE_MONEY = 4'd9,
        CHECK_MONEY  = 4'd10,
        NEXT_STAGE   = 4'd11,
        GAME_OVER    = 4'd12,
        GAME_CLEAR   = 4'd13
    } game_state_e;

    // ------------------------------
    // Control bundles
    // ------------------------------
    // Sequencer to bet amount unit
    typedef struct packed {
        logic load_digit;
        logic clear;
    } bet_ctl_t;

    // Sequencer to pick unit
    typedef struct packed {
        logic load_count;
        logic clear_count;
        logic load_number;
        logic clear_numbers;
        logic round_clear;
    } pick_ctl_t;

    // Chosen wheel positions, zero-based
    typedef struct packed {
        slot_t slot0;
        slot_t slot1;
        slot_t slot2;
        slot_t slot3;
    } picks_t;

    // One-cycle strobes to the outside blocks
    typedef struct packed {
        logic clear_input;
        logic start_spin;
        logic update_money_req;
        logic reset_round;
        logic game_reset;
    } round_pulses_t;

endpackage

`default_nettype wire

// File: source/round_sequencer.sv
/*
 * Round sequencer of the roulette controller.
 * Classifies keys, steps the game FSM and issues entry commands and pulses.
 */
`timescale 1ns/1ps
`include "roulette_consts.svh"
`default_nettype none

module round_sequencer
    import roulette_pkg::*;
(
    input  wire              clk,
    input  wire              rst,
    input  wire              key_valid,
    input  wire key_code_t   key_value,
    input  wire              spin_done,
    input  wire              win_flag,
    input  wire              money_zero,
    input  wire              money_10000,
    input  wire              bet_ok,
    input  wire              count_ok,
    input  wire              picks_ok,
    output game_state_e      state,
    output bet_ctl_t         bet_ctl,
    output pick_ctl_t        pick_ctl,
    output round_pulses_t    pulses
);

    game_state_e state_next;

    logic is_digit;
    logic is_star;
    logic is_hash;
    logic in_entry;
    logic star_reject;
    logic entry_clear;
    logic round_clear;
    logic new_game;
    logic [4:0] pulse_bits;

    // ------------------------------
    // Key classification
    // ------------------------------
    assign is_digit = key_valid && (key_value <= key_code_t'(`ROULETTE_MAX_DIGIT));
    assign is_star  = key_valid && (key_value == key_code_t'(`ROULETTE_KEY_STAR));
    assign is_hash  = key_valid && (key_value == key_code_t'(`ROULETTE_KEY_HASH));

    // States that take keypad entry
    assign in_entry = (state == BET_MONEY) || (state == BET_SELECT) ||
                      (state == NUMBER_INPUT);

    // Confirm with bad data in the current entry step
    assign star_reject = is_star && (((state == BET_MONEY) && !bet_ok) ||
                                     ((state == BET_SELECT) && !count_ok) ||
                                     ((state == NUMBER_INPUT) && !picks_ok));

    assign entry_clear = (is_hash && in_entry) || star_reject;

    // '*' leaving an end-of-round state starts a fresh round
    assign round_clear = is_star && ((state == IDLE) || (state == NEXT_STAGE) ||
                                     (state == GAME_OVER) || (state == GAME_CLEAR));

    // Full game restart, balance included
    assign new_game = is_star && ((state == IDLE) || (state == GAME_OVER) ||
                                  (state == GAME_CLEAR));

    // ------------------------------
    // Entry commands
    // ------------------------------
    always_comb begin
        bet_ctl.load_digit      = is_digit && (state == BET_MONEY);
        bet_ctl.clear           = entry_clear && (state == BET_MONEY);
        pick_ctl.load_count     = is_digit && (state == BET_SELECT);
        pick_ctl.clear_count    = entry_clear && (state == BET_SELECT);
        pick_ctl.load_number    = is_digit && (state == NUMBER_INPUT);
        pick_ctl.clear_numbers  = entry_clear && (state == NUMBER_INPUT);
        pick_ctl.round_clear    = round_clear;
    end

    // ------------------------------
    // Next state
    // ------------------------------
    always_comb begin
        state_next = state;
        case (state)
            IDLE, NEXT_STAGE: if (is_star) state_next = BET_MONEY;
            BET_MONEY:    if (is_star && bet_ok) state_next = BET_SELECT;
            BET_SELECT:   if (is_star && count_ok) state_next = NUMBER_INPUT;
            NUMBER_INPUT: if (is_star && picks_ok) state_next = START_SPIN;
            START_SPIN:   state_next = SLOW_DOWN;
            // Wait on the spinner
            SLOW_DOWN:    if (spin_done) state_next = STOP_RESULT;
            STOP_RESULT:  state_next = win_flag ? WIN_DISPLAY : LOSE_DISPLAY;
            WIN_DISPLAY, LOSE_DISPLAY: state_next = UPDATE_MONEY;
            UPDATE_MONEY: state_next = CHECK_MONEY;
            CHECK_MONEY: begin
                // Empty balance wins over the clear target
                if (money_zero) begin
                    state_next = GAME_OVER;
                end else if (money_10000) begin
                    state_next = GAME_CLEAR;
                end else begin
                    state_next = NEXT_STAGE;
                end
            end
            GAME_OVER, GAME_CLEAR: if (is_star) state_next = IDLE;
            default: state_next = IDLE;
        endcase
    end

    // ------------------------------
    // State and pulse registers
    // ------------------------------
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state  <= IDLE;
            pulses <= '0;
        end else begin
            state                   <= state_next;
            pulses.clear_input      <= entry_clear;
            // High in the first SLOW_DOWN cycle
            pulses.start_spin       <= (state == START_SPIN);
            // High during UPDATE_MONEY
            pulses.update_money_req <= (state == WIN_DISPLAY) || (state == LOSE_DISPLAY);
            pulses.reset_round      <= round_clear;
            pulses.game_reset       <= new_game;
        end
    end

    assign pulse_bits = pulses;

    // Spin start and money update belong to different round phases
    a_spin_update_excl: assert property (
        @(posedge clk) disable iff (rst)
        !(pulses.start_spin && pulses.update_money_req)
    ) else $error("round_sequencer: start_spin and update_money_req together");

    // Every strobe drops after one cycle
    a_pulse_one_cycle: assert property (
        @(posedge clk) disable iff (rst)
        (pulse_bits & $past(pulse_bits)) == 5'b0
    ) else $error("round_sequencer: pulse held for two cycles");

endmodule

`default_nettype wire

// File: verification/tb_roulette_ctrl.sv
/*
 * Testbench for the roulette game controller.
 * Plays keypad rounds against a model of the spinner and money manager,
 * checking state, entry registers and pulses after every key.
 */
`timescale 1ns/1ps
`include "roulette_consts.svh"
`default_nettype none

module tb_roulette_ctrl
    import roulette_pkg::*;
();

    localparam int KEY_STAR      = `ROULETTE_KEY_STAR;
    localparam int KEY_HASH      = `ROULETTE_KEY_HASH;
    localparam int MAX_DIGIT     = `ROULETTE_MAX_DIGIT;
    localparam int MAX_PICKS     = `ROULETTE_MAX_PICKS;
    localparam int NUM_SLOTS     = `ROULETTE_NUM_SLOTS;
    localparam int START_BALANCE = 5000;
    localparam int CLEAR_BALANCE = 10000;
    localparam int MAX_SPIN      = 20;
    localparam int NUM_ROUNDS    = 24;
    // Budget of 40 rounds at 200 cycles each
    localparam int MAX_CYCLES    = 40 * 200;

    logic          clk = 1'b0;
    logic          rst;
    logic          key_valid;
    key_code_t     key_value;
    logic          spin_done = 1'b0;
    logic          win_flag = 1'b0;
    logic          money_zero;
    logic          money_10000;
    money_t        current_money;
    game_state_e   state;
    pick_count_t   bet_count;
    money_t        bet_amount;
    picks_t        picks;
    round_pulses_t pulses;

    int seed = 32'hc886c64b;

    // Environment model state
    money_t balance = money_t'(START_BALANCE);
    int spin_left = 0;
    int spin_delay = 0;
    int update_count = 0;
    int cycle_count = 0;
    int fail_count = 0;
    int over_count = 0;
    int clear_count = 0;
    int next_count = 0;

    // Expected controller contents
    game_state_e exp_state;
    money_t      exp_amount;
    int          exp_count;
    int          exp_entered;
    slot_t       exp_slot [4];

    // Money manager flags follow the balance
    assign current_money = balance;
    assign money_zero    = (balance == '0);
    assign money_10000   = (balance >= money_t'(CLEAR_BALANCE));

    roulette_ctrl i_roulette_ctrl (
        .clk           (clk),
        .rst           (rst),
        .key_valid     (key_valid),
        .key_value     (key_value),
        .spin_done     (spin_done),
        .win_flag      (win_flag),
        .money_zero    (money_zero),
        .money_10000   (money_10000),
        .current_money (current_money),
        .state         (state),
        .bet_count     (bet_count),
        .bet_amount    (bet_amount),
        .picks         (picks),
        .pulses        (pulses)
    );

    // 100 ns clock
    always #50 clk = ~clk;

    // ------------------------------
    // Failure and checking
    // ------------------------------
    task automatic fail_run(input string why);
        $display("%s", why);
        $display("sim failed");
        $fatal(1, "run stopped");
    endtask

    task automatic check_value(input int actual, input int expected, input string what);
        if (actual != expected) begin
            fail_count = fail_count + 1;
            fail_run($sformatf("error at time %0t: %s, got %0d, expected %0d",
                               $time, what, actual, expected));
        end
    endtask

    // Run length guard
    always @(posedge clk) begin
        cycle_count = cycle_count + 1;
        if (cycle_count >= MAX_CYCLES)
            fail_run($sformatf("timeout: the run did not finish within %0d cycles",
                               MAX_CYCLES));
    end

    function automatic int rand_below(input int n);
        int r;
        r = $random(seed);
        return (r & 32'h7fff_ffff) % n;
    endfunction

    // ------------------------------
    // Spinner and money manager model
    // ------------------------------
    always @(negedge clk) begin
        spin_done = 1'b0;
        if (pulses.start_spin) begin
            // New spin, random length and outcome
            spin_delay = 1 + rand_below(MAX_SPIN);
            spin_left  = spin_delay;
            win_flag   = (rand_below(2) == 1);
        end else if (spin_left > 0) begin
            spin_left = spin_left - 1;
            spin_done = (spin_left == 0);
        end
        if (pulses.update_money_req) begin
            update_count = update_count + 1;
            if (win_flag)
                balance = balance + exp_amount;
            else
                balance = balance - exp_amount;
        end
        // New game restores the starting balance
        if (pulses.game_reset)
            balance = money_t'(START_BALANCE);
    end

    // ------------------------------
    // Reference functions
    // ------------------------------
    // Decimal shift and add, kept to 16 bits
    function automatic money_t amount_after_digit(input money_t a, input int d);
        return money_t'((int'(a) * 10 + d) % 65536);
    endfunction

    function automatic bit bet_valid(input money_t a, input money_t bal);
        return (a != '0) && (a <= bal);
    endfunction

    // Keys 1 to 8 map onto wheel slots 0 to 7
    function automatic slot_t slot_for_key(input int k);
        return slot_t'(k - 1);
    endfunction

    function automatic game_state_e state_after_key(input game_state_e s, input int k,
                                                    input bit ok);
        game_state_e n;
        n = s;
        if (k == KEY_STAR) begin
            case (s)
                IDLE, NEXT_STAGE: n = BET_MONEY;
                BET_MONEY:        n = ok ? BET_SELECT : s;
                BET_SELECT:       n = ok ? NUMBER_INPUT : s;
                NUMBER_INPUT:     n = ok ? START_SPIN : s;
                GAME_OVER, GAME_CLEAR: n = IDLE;
                default:          n = s;
            endcase
        end
        return n;
    endfunction

    // ------------------------------
    // Output comparison
    // ------------------------------
    task automatic check_outputs(input string what);
        check_value(int'(state), int'(exp_state), $sformatf("%s: state", what));
        check_value(int'(bet_amount), int'(exp_amount), $sformatf("%s: bet_amount", what));
        check_value(int'(bet_count), exp_count, $sformatf("%s: bet_count", what));
        check_value(int'(picks), int'({exp_slot[0], exp_slot[1], exp_slot[2], exp_slot[3]}),
                    $sformatf("%s: picks", what));
    endtask

    task automatic check_pulses(input bit c, input bit s, input bit u, input bit r,
                                input bit g, input string what);
        check_value(int'(pulses), int'({c, s, u, r, g}), $sformatf("%s: pulses", what));
    endtask

    task automatic clear_entries();
        exp_amount  = '0;
        exp_count   = 0;
        exp_entered = 0;
        foreach (exp_slot[i])
            exp_slot[i] = '0;
    endtask

    // ------------------------------
    // Keypad stimulus
    // ------------------------------
    // Called on a falling edge; strobe lasts one cycle
    task automatic press_key(input int k);
        bit ok;
        bit entry;
        bit is_star;
        bit is_hash;
        bit exp_clear;
        bit exp_round;
        bit exp_game;
        game_state_e nxt;
        is_star = (k == KEY_STAR);
        is_hash = (k == KEY_HASH);
        // Confirm validity of the current entry step
        case (exp_state)
            BET_MONEY:    ok = bet_valid(exp_amount, balance);
            BET_SELECT:   ok = (exp_count >= 1) && (exp_count <= MAX_PICKS);
            NUMBER_INPUT: ok = (exp_count != 0) && (exp_entered == exp_count);
            default:      ok = 1'b1;
        endcase
        entry     = exp_state inside {BET_MONEY, BET_SELECT, NUMBER_INPUT};
        exp_clear = entry && (is_hash || (is_star && !ok));
        exp_round = is_star && (exp_state inside {IDLE, NEXT_STAGE, GAME_OVER, GAME_CLEAR});
        exp_game  = is_star && (exp_state inside {IDLE, GAME_OVER, GAME_CLEAR});
        nxt       = state_after_key(exp_state, k, ok);

        // Entry registers after the sampling edge
        if (exp_round) begin
            clear_entries();
        end else if (exp_state == BET_MONEY) begin
            if (exp_clear)
                exp_amount = '0;
            else if (k <= MAX_DIGIT)
                exp_amount = amount_after_digit(exp_amount, k);
        end else if (exp_state == BET_SELECT) begin
            if (exp_clear)
                exp_count = 0;
            else if ((k >= 1) && (k <= MAX_PICKS))
                exp_count = k;
        end else if (exp_state == NUMBER_INPUT) begin
            if (exp_clear) begin
                exp_entered = 0;
                foreach (exp_slot[i])
                    exp_slot[i] = '0;
            end else if ((k >= 1) && (k <= NUM_SLOTS) && (exp_entered < exp_count)) begin
                exp_slot[2'(exp_entered)] = slot_for_key(k);
                exp_entered = exp_entered + 1;
            end
        end
        exp_state = nxt;

        key_valid = 1'b1;
        key_value = key_code_t'(k);
        @(negedge clk);
        key_valid = 1'b0;
        check_outputs("after key");
        check_pulses(exp_clear, 1'b0, 1'b0, exp_round, exp_game, "after key");
        // Strobes drop and entry holds with no key
        if (nxt != START_SPIN) begin
            @(negedge clk);
            check_outputs("idle after key");
            check_pulses(1'b0, 1'b0, 1'b0, 1'b0, 1'b0, "idle after key");
        end
    endtask

    // Decimal digits, most significant first
    task automatic type_number(input int value);
        int digits[$];
        int v;
        v = value;
        do begin
            digits.push_front(v % 10);
            v = v / 10;
        end while (v != 0);
        foreach (digits[i])
            press_key(digits[i]);
    endtask

    // ------------------------------
    // Spin and money update
    // ------------------------------
    // Starts in the START_SPIN cycle
    task automatic run_spin();
        int waited;
        int updates_before;
        int new_balance;
        bit win;
        game_state_e result;
        updates_before = update_count;
        @(negedge clk);
        exp_state = SLOW_DOWN;
        check_outputs("spin start");
        check_pulses(1'b0, 1'b1, 1'b0, 1'b0, 1'b0, "spin start");

        // Wait on spin_done through the state change
        waited = 0;
        while ((state == SLOW_DOWN) && (waited <= MAX_SPIN + 1)) begin
            @(negedge clk);
            waited = waited + 1;
        end
        if (state == SLOW_DOWN)
            fail_run("spin_done never moved the controller out of SLOW_DOWN");
        check_value(waited, spin_delay + 1, "cycles in SLOW_DOWN");
        exp_state = STOP_RESULT;
        check_outputs("stop result");

        win = win_flag;
        if (win)
            new_balance = int'(balance) + int'(exp_amount);
        else
            new_balance = int'(balance) - int'(exp_amount);
        @(negedge clk);
        exp_state = win ? WIN_DISPLAY : LOSE_DISPLAY;
        check_outputs("result display");
        @(negedge clk);
        exp_state = UPDATE_MONEY;
        check_outputs("update money");
        check_pulses(1'b0, 1'b0, 1'b1, 1'b0, 1'b0, "update money");
        @(negedge clk);
        exp_state = CHECK_MONEY;
        check_outputs("check money");
        check_pulses(1'b0, 1'b0, 1'b0, 1'b0, 1'b0, "check money");
        check_value(int'(balance), new_balance, "balance after update");
        check_value(update_count, updates_before + 1, "money updates per round");

        // Empty balance first, then the clear target
        if (new_balance == 0) begin
            result = GAME_OVER;
            over_count = over_count + 1;
        end else if (new_balance >= CLEAR_BALANCE) begin
            result = GAME_CLEAR;
            clear_count = clear_count + 1;
        end else begin
            result = NEXT_STAGE;
            next_count = next_count + 1;
        end
        @(negedge clk);
        exp_state = result;
        check_outputs("round end");
    endtask

    // ------------------------------
    // One round from BET_MONEY
    // ------------------------------
    task automatic play_round(input bit full_bet);
        int n;
        int amount;
        int count;
        // Random digit run, may wrap
        n = 1 + rand_below(6);
        repeat (n)
            press_key(rand_below(10));
        press_key(KEY_HASH);
        // Zero amount, then one above the balance
        press_key(KEY_STAR);
        type_number(int'(balance) + 1);
        press_key(KEY_STAR);
        if (full_bet)
            amount = int'(balance);
        else
            amount = 1 + rand_below((int'(balance) < 500) ? int'(balance) : 500);
        type_number(amount);
        press_key(KEY_STAR);

        // Bet count, zero count rejected first
        press_key(KEY_STAR);
        repeat (3)
            press_key(rand_below(10));
        press_key(KEY_HASH);
        count = 1 + rand_below(MAX_PICKS);
        press_key(count);
        press_key(KEY_STAR);

        // Out of range keys, then an early confirm
        press_key(0);
        press_key(MAX_DIGIT);
        repeat (count - 1)
            press_key(1 + rand_below(NUM_SLOTS));
        press_key(KEY_STAR);
        repeat (count)
            press_key(1 + rand_below(NUM_SLOTS));
        // Extra number past the count
        press_key(1 + rand_below(NUM_SLOTS));
        press_key(KEY_STAR);
        run_spin();

        // End states ignore everything but '*'
        press_key(KEY_HASH);
        press_key(rand_below(10));
        press_key(KEY_STAR);
        if (exp_state == IDLE)
            press_key(KEY_STAR);
    endtask

    // ------------------------------
    // Main sequence
    // ------------------------------
    initial begin
        int round;
        rst       = 1'b1;
        key_valid = 1'b0;
        key_value = '0;
        exp_state = IDLE;
        clear_entries();
        repeat (16) @(negedge clk);
        rst = 1'b0;

        check_outputs("after reset");
        check_pulses(1'b0, 1'b0, 1'b0, 1'b0, 1'b0, "after reset");
        // First '*' starts a game
        press_key(KEY_STAR);
        check_value(int'(state), int'(BET_MONEY), "state after first star");

        for (round = 0; round < NUM_ROUNDS; round++)
            play_round(round % 3 == 2);

        $display("rounds: %0d next stage, %0d game over, %0d game clear",
                 next_count, over_count, clear_count);
        if (fail_count == 0) begin
            $display("sim passed");
            $finish;
        end else begin
            fail_run("mismatches were recorded during the run");
        end
    end

endmodule

`default_nettype wire
